// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpri_packer
RTL_TOP   ?= cpri_packer
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/cpri_packer.sv
`timescale 1ns/1ps

module cpri_packer
    import word_pkg::*;
    import frame_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_vld,
    input  logic                              i_sop,
    input  logic                              i_eop,
    input  logic [num_ant-1:0][sample_w-1:0]  i_ant_data,
    input  logic [num_ant-1:0][shift_w-1:0]   i_ant_shift,
    input  logic [ch_type_w-1:0]              i_ch_type,
    input  logic                              i_cell_idx,
    input  logic [slot_idx_w-1:0]             i_slot_idx,
    input  logic [sym_idx_w-1:0]              i_sym_idx,
    input  logic [prb_idx_w-1:0]              i_prb_idx,
    input  logic [hdr_info_w-1:0]             i_info,
    output logic                              o_credit,
    output logic                              o_wen,
    output logic [addr_w-1:0]                 o_waddr,
    output cpri_word_u                        o_wdata,
    output logic                              o_wlast
);

    logic [addr_w-1:0]                wr_addr;
    logic [slot_w-1:0]                wr_slot;
    logic                             wr_last;
    logic [addr_w-1:0]                rd_addr;
    logic [slot_w-1:0]                rd_slot;
    logic                             rd_active;
    logic [phase_w-1:0]               phase;
    logic [pos_w-1:0]                 pos;
    logic [group_w-1:0]               group;
    logic                             frame_last;
    logic [info_w-1:0]                info;
    logic [num_ant-1:0][sample_w-1:0] rd_data;
    logic [info_w-1:0]                rd_info;
    logic [num_ant-1:0][lane_w-1:0]   lanes;

    pkt_ctrl pkt_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_vld        (i_vld),
        .i_sop        (i_sop),
        .i_eop        (i_eop),
        .o_wr_addr    (wr_addr),
        .o_wr_slot    (wr_slot),
        .o_wr_last    (wr_last),
        .o_rd_addr    (rd_addr),
        .o_rd_slot    (rd_slot),
        .o_rd_active  (rd_active),
        .o_phase      (phase),
        .o_pos        (pos),
        .o_group      (group),
        .o_frame_last (frame_last),
        .o_credit     (o_credit)
    );

    header_capture header_capture_i (
        .clk         (clk),
        .i_vld       (i_vld),
        .i_sop       (i_sop),
        .i_phase     (phase),
        .i_ch_type   (i_ch_type),
        .i_cell_idx  (i_cell_idx),
        .i_slot_idx  (i_slot_idx),
        .i_sym_idx   (i_sym_idx),
        .i_prb_idx   (i_prb_idx),
        .i_info      (i_info),
        .i_ant_shift (i_ant_shift),
        .o_info      (info)
    );

    pkt_buffer pkt_buffer_i (
        .clk       (clk),
        .i_wen     (i_vld),
        .i_wr_slot (wr_slot),
        .i_wr_addr (wr_addr),
        .i_wr_data (i_ant_data),
        .i_wr_last (wr_last),
        .i_wr_info (info),
        .i_rd_slot (rd_slot),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data),
        .o_rd_info (rd_info)
    );

    sample_repack sample_repack_i (
        .clk      (clk),
        .i_active (rd_active),
        .i_pos    (pos),
        .i_data   (rd_data),
        .o_lanes  (lanes)
    );

    frame_writer frame_writer_i (
        .clk          (clk),
        .rst          (rst),
        .i_active     (rd_active),
        .i_pos        (pos),
        .i_group      (group),
        .i_frame_last (frame_last),
        .i_lanes      (lanes),
        .i_info       (rd_info),
        .o_wen        (o_wen),
        .o_waddr      (o_waddr),
        .o_wdata      (o_wdata),
        .o_wlast      (o_wlast)
    );

endmodule

// File: rtl/frame_pkg.sv
package frame_pkg;

    // ------------------------------
    // frame geometry
    // ------------------------------
    localparam int group_len  = 8;
    localparam int num_groups = 12;
    localparam int pkt_words  = num_groups * group_len;
    localparam int addr_w     = 7;
    localparam int pos_w      = $clog2(group_len);
    localparam int group_w    = addr_w - pos_w;

    // ------------------------------
    // address map
    // ------------------------------
    localparam logic [addr_w-1:0]  data_first      = 7'd7;
    localparam logic [addr_w-1:0]  data_last       = 7'd90;
    // groups below this write control words to address == group
    localparam logic [group_w-1:0] ctrl_low_groups = 4'd7;
    localparam logic [addr_w-1:0]  ctrl_high_base  = 7'd84;
    localparam logic [group_w-1:0] head_group      = 4'd3;
    localparam logic [group_w-1:0] shift_group0    = 4'd5;
    localparam logic [group_w-1:0] shift_group1    = 4'd6;

    // slots, credits, packet phase
    localparam int num_slots    = 2;
    localparam int slot_w       = $clog2(num_slots);
    localparam int init_credits = num_slots;
    localparam int phase_w      = 3;
    localparam logic [phase_w-1:0] prb1_phase = 3'd4;

endpackage

// File: rtl/frame_writer.sv
`timescale 1ns/1ps

module frame_writer
    import word_pkg::*;
    import frame_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_active,
    input  logic [pos_w-1:0]                i_pos,
    input  logic [group_w-1:0]              i_group,
    input  logic                            i_frame_last,
    input  logic [num_ant-1:0][lane_w-1:0]  i_lanes,
    input  logic [info_w-1:0]               i_info,
    output logic                            o_wen,
    output logic [addr_w-1:0]               o_waddr,
    output cpri_word_u                      o_wdata,
    output logic                            o_wlast
);

    logic [addr_w-1:0] addr_d;
    logic [word_w-1:0] ctrl_d;
    logic              act_q;
    logic              last_q;
    logic              is_ctrl_q;
    logic [addr_w-1:0] addr_q;
    cpri_word_u        ctrl_q;

    // ------------------------------
    // address map
    // ------------------------------
    always_comb
    begin
        if (i_pos != '0)
            addr_d = data_first + addr_w'(i_group) * addr_w'(group_len - 1)
                     + addr_w'(i_pos) - 1'b1;
        else if (i_group < ctrl_low_groups)
            addr_d = addr_w'(i_group);
        else
            addr_d = addr_w'(i_group) + ctrl_high_base;
    end

    // control word per group
    always_comb
    begin
        case (i_group)
            head_group:   ctrl_d = i_info[0 +: word_w];
            shift_group0: ctrl_d = i_info[word_w +: word_w];
            shift_group1: ctrl_d = i_info[2*word_w +: word_w];
            default:      ctrl_d = '0;
        endcase
    end

    // control side staged one cycle to meet the repacked lanes
    always_ff @(posedge clk)
    begin
        if (rst)
            act_q <= 1'b0;
        else
            act_q <= i_active;
    end

    always_ff @(posedge clk)
    begin
        last_q    <= i_frame_last;
        is_ctrl_q <= (i_pos == '0);
        addr_q    <= addr_d;
        ctrl_q    <= ctrl_d;
    end

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_wen   <= 1'b0;
            o_wlast <= 1'b0;
        end
        else
        begin
            o_wen   <= act_q;
            o_wlast <= act_q && last_q;
        end
    end

    always_ff @(posedge clk)
    begin
        o_waddr <= addr_q;
        if (is_ctrl_q)
            o_wdata <= ctrl_q;
        else
            o_wdata.lanes <= i_lanes;
    end

endmodule

// File: rtl/header_capture.sv
`timescale 1ns/1ps

module header_capture
    import word_pkg::*;
    import frame_pkg::*;
(
    input  logic                             clk,
    input  logic                             i_vld,
    input  logic                             i_sop,
    input  logic [phase_w-1:0]               i_phase,
    input  logic [ch_type_w-1:0]             i_ch_type,
    input  logic                             i_cell_idx,
    input  logic [slot_idx_w-1:0]            i_slot_idx,
    input  logic [sym_idx_w-1:0]             i_sym_idx,
    input  logic [prb_idx_w-1:0]             i_prb_idx,
    input  logic [hdr_info_w-1:0]            i_info,
    input  logic [num_ant-1:0][shift_w-1:0]  i_ant_shift,
    output logic [info_w-1:0]                o_info
);

    cpri_word_u head_q;
    cpri_word_u head_d;
    // eight nibbles per antenna, two phase halves of four PRB slots
    logic [num_ant-1:0][7:0][shift_w-1:0] shift_q;
    logic [num_ant-1:0][7:0][shift_w-1:0] shift_d;
    logic [2:0] nib_idx;

    assign nib_idx = {i_phase[phase_w-1], i_prb_idx[1:0]};

    always_comb
    begin
        head_d          = head_q;
        shift_d         = shift_q;
        head_d.head.pad = '0;
        if (i_vld)
        begin
            // common fields follow every word of a phase 0 packet
            if (i_phase == '0)
            begin
                head_d.head.ch_type  = i_ch_type;
                head_d.head.cell_idx = i_cell_idx;
                head_d.head.slot_idx = i_slot_idx;
                head_d.head.sym_idx  = i_sym_idx;
            end
            if (i_sop && i_phase == '0)
            begin
                head_d.head.prb0  = i_prb_idx[prb_w-1:0];
                head_d.head.info0 = i_info[hdr_info_w-1 -: info_hi_w];
            end
            if (i_sop && i_phase == prb1_phase)
            begin
                head_d.head.prb1  = i_prb_idx[prb_w-1:0];
                head_d.head.info1 = i_info[hdr_info_w-1 -: info_hi_w];
            end
            for (int a = 0; a < num_ant; a++)
            begin
                shift_d[a][nib_idx] = i_ant_shift[a];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        head_q  <= head_d;
        shift_q <= shift_d;
    end

    // includes the current word, so the eop word lands in the snapshot
    assign o_info = {shift_d, head_d};

endmodule

// File: rtl/pkt_buffer.sv
`timescale 1ns/1ps

module pkt_buffer
    import word_pkg::*;
    import frame_pkg::*;
(
    input  logic                              clk,
    input  logic                              i_wen,
    input  logic [slot_w-1:0]                 i_wr_slot,
    input  logic [addr_w-1:0]                 i_wr_addr,
    input  logic [num_ant-1:0][sample_w-1:0]  i_wr_data,
    input  logic                              i_wr_last,
    input  logic [info_w-1:0]                 i_wr_info,
    input  logic [slot_w-1:0]                 i_rd_slot,
    input  logic [addr_w-1:0]                 i_rd_addr,
    output logic [num_ant-1:0][sample_w-1:0]  o_rd_data,
    output logic [info_w-1:0]                 o_rd_info
);

    // sample storage, one packet per slot
    logic [num_ant-1:0][sample_w-1:0] mem [num_slots][pkt_words];

    // control words captured with each packet
    logic [info_w-1:0] info_q [num_slots];

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (i_wen)
            mem[i_wr_slot][i_wr_addr] <= i_wr_data;
    end

    // snapshot taken on the packet's last word
    always_ff @(posedge clk)
    begin
        if (i_wr_last)
            info_q[i_wr_slot] <= i_wr_info;
    end

    // ------------------------------
    // read port
    // ------------------------------
    always_ff @(posedge clk)
    begin
        o_rd_data <= mem[i_rd_slot][i_rd_addr];
        o_rd_info <= info_q[i_rd_slot];
    end

endmodule

// File: rtl/pkt_ctrl.sv
`timescale 1ns/1ps

module pkt_ctrl
    import frame_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_vld,
    input  logic                i_sop,
    input  logic                i_eop,
    output logic [addr_w-1:0]   o_wr_addr,
    output logic [slot_w-1:0]   o_wr_slot,
    output logic                o_wr_last,
    output logic [addr_w-1:0]   o_rd_addr,
    output logic [slot_w-1:0]   o_rd_slot,
    output logic                o_rd_active,
    output logic [phase_w-1:0]  o_phase,
    output logic [pos_w-1:0]    o_pos,
    output logic [group_w-1:0]  o_group,
    output logic                o_frame_last,
    output logic                o_credit
);

    logic [addr_w-1:0]    wr_addr;
    logic [slot_w-1:0]    wr_slot;
    logic [phase_w-1:0]   phase;
    logic [num_slots-1:0] full;
    logic                 rd_on;
    logic [addr_w-1:0]    rd_addr;
    logic [slot_w-1:0]    rd_slot;
    logic [slot_w-1:0]    rd_next;
    logic                 wr_done;
    logic                 rd_done;

    assign wr_done = i_vld && i_eop;
    assign rd_done = rd_on && (rd_addr == addr_w'(pkt_words - 1));
    assign rd_next = rd_slot + 1'b1;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_addr <= '0;
            wr_slot <= '0;
            phase   <= '0;
        end
        else if (i_vld)
        begin
            if (i_eop)
            begin
                wr_addr <= '0;
                wr_slot <= wr_slot + 1'b1;
                phase   <= phase + 1'b1;
            end
            else
                wr_addr <= wr_addr + 1'b1;
        end
    end

    // slot full flags, set on packet end and cleared after the last read
    always_ff @(posedge clk)
    begin
        if (rst)
            full <= '0;
        else
        begin
            if (wr_done)
                full[wr_slot] <= 1'b1;
            if (rd_done)
                full[rd_slot] <= 1'b0;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // back-to-back readout when the other slot is already waiting
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_on   <= 1'b0;
            rd_addr <= '0;
            rd_slot <= '0;
        end
        else if (rd_done)
        begin
            rd_addr <= '0;
            rd_slot <= rd_next;
            rd_on   <= full[rd_next];
        end
        else if (rd_on)
            rd_addr <= rd_addr + 1'b1;
        else
            rd_on <= full[rd_slot];
    end

    // status lined up with the buffer read data
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_rd_active  <= 1'b0;
            o_frame_last <= 1'b0;
            o_credit     <= 1'b0;
        end
        else
        begin
            o_rd_active  <= rd_on;
            o_frame_last <= rd_done;
            o_credit     <= rd_done;
        end
    end

    always_ff @(posedge clk)
    begin
        o_pos   <= rd_addr[pos_w-1:0];
        o_group <= rd_addr[addr_w-1:pos_w];
    end

    assign o_wr_addr = wr_addr;
    assign o_wr_slot = wr_slot;
    assign o_wr_last = wr_done;
    assign o_rd_addr = rd_addr;
    assign o_rd_slot = rd_slot;
    assign o_phase   = phase;

    // source credits must keep a new packet out of a slot still waiting for readout
    assert property (@(posedge clk) disable iff (rst) i_vld && i_sop |-> !full[wr_slot])
        else $error("pkt_ctrl: packet start into a full slot");

    assert property (@(posedge clk) disable iff (rst)
        i_vld && i_eop |-> wr_addr == addr_w'(pkt_words - 1))
        else $error("pkt_ctrl: eop not on the last packet word");

endmodule

// File: rtl/sample_repack.sv
`timescale 1ns/1ps

module sample_repack
    import word_pkg::*;
    import frame_pkg::*;
(
    input  logic                              clk,
    input  logic                              i_active,
    input  logic [pos_w-1:0]                  i_pos,
    input  logic [num_ant-1:0][sample_w-1:0]  i_data,
    output logic [num_ant-1:0][lane_w-1:0]    o_lanes
);

    logic [num_ant-1:0][sample_w-1:0]   prev_q;
    logic [num_ant-1:0][2*sample_w-1:0] pair;
    // lane k starts 2(k-1) bits into the previous sample
    logic [pos_w:0] offset;

    assign offset = {i_pos - 1'b1, 1'b0};

    for (genvar a = 0; a < num_ant; a++)
    begin : g_pair
        assign pair[a] = {i_data[a], prev_q[a]};
    end

    // ------------------------------
    // 8 x 14 bit in, 7 x 16 bit out
    // ------------------------------
    always_ff @(posedge clk)
    begin
        prev_q <= i_data;
        for (int a = 0; a < num_ant; a++)
        begin
            // position 0 is the slot taken by the control word
            if (i_active && i_pos != '0)
                o_lanes[a] <= pair[a][offset +: lane_w];
            else
                o_lanes[a] <= '0;
        end
    end

    // the previous sample is only valid if the read stream had no gap
    assert property (@(posedge clk)
        i_active && i_pos != '0 |-> $past(i_active) && $past(i_pos) == pos_w'(i_pos - 1'b1))
        else $error("sample_repack: read position out of sequence");

endmodule

// File: rtl/word_pkg.sv
package word_pkg;

    // ------------------------------
    // sample and word widths
    // ------------------------------
    localparam int sample_w   = 14;
    localparam int lane_w     = 16;
    localparam int num_ant    = 4;
    localparam int shift_w    = 4;
    localparam int word_w     = 64;
    // head, shift ant 0-1, shift ant 2-3
    localparam int ctrl_words = 3;
    localparam int info_w     = ctrl_words * word_w;

    // header fields
    localparam int ch_type_w  = 4;
    localparam int prb_w      = 8;
    localparam int prb_idx_w  = 9;
    localparam int slot_idx_w = 7;
    localparam int sym_idx_w  = 4;
    localparam int hdr_info_w = 8;
    localparam int info_hi_w  = 4;

    // one CPRI write word, either four sample lanes or the header
    typedef union packed {
        logic [num_ant-1:0][lane_w-1:0] lanes;
        struct packed {
            logic [23:0]           pad;
            logic [ch_type_w-1:0]  ch_type;
            logic [prb_w-1:0]      prb0;
            logic [prb_w-1:0]      prb1;
            logic                  cell_idx;
            logic [slot_idx_w-1:0] slot_idx;
            logic [sym_idx_w-1:0]  sym_idx;
            logic [info_hi_w-1:0]  info0;
            logic [info_hi_w-1:0]  info1;
        } head;
    } cpri_word_u;

endpackage

// File: tb/tb_cpri_packer.sv
`timescale 1ns/1ps

module tb_cpri_packer
    import word_pkg::*;
    import frame_pkg::*;
();

    localparam int num_pkts  = 20;
    localparam int wait_max  = 5000;

    logic                             clk;
    logic                             rst;
    logic                             i_vld;
    logic                             i_sop;
    logic                             i_eop;
    logic [num_ant-1:0][sample_w-1:0] i_ant_data;
    logic [num_ant-1:0][shift_w-1:0]  i_ant_shift;
    logic [ch_type_w-1:0]             i_ch_type;
    logic                             i_cell_idx;
    logic [slot_idx_w-1:0]            i_slot_idx;
    logic [sym_idx_w-1:0]             i_sym_idx;
    logic [prb_idx_w-1:0]             i_prb_idx;
    logic [hdr_info_w-1:0]            i_info;
    logic                             o_credit;
    logic                             o_wen;
    logic [addr_w-1:0]                o_waddr;
    cpri_word_u                       o_wdata;
    logic                             o_wlast;

    // reference model state
    cpri_word_u                           head_m;
    logic [num_ant-1:0][7:0][shift_w-1:0] shift_m;
    logic [num_ant-1:0][sample_w-1:0]     pkt_smp [pkt_words];
    logic [addr_w-1:0] exp_addr [$];
    logic [word_w-1:0] exp_data [$];
    bit                exp_chk [$];
    int                eop_q [$];
    int cyc = 0;
    int credits = init_credits;
    int credits_seen = 0;
    int frames_done = 0;
    int wcnt = 0;
    int last_s = -1000;

    cpri_packer cpri_packer_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic die(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    function automatic string show_word(input logic [addr_w-1:0] addr, input cpri_word_u w);
        if (addr == addr_w'(head_group))
            return $sformatf("ch %h prb0 %h prb1 %h cell %h slot %h sym %h inf %h/%h",
                w.head.ch_type, w.head.prb0, w.head.prb1, w.head.cell_idx,
                w.head.slot_idx, w.head.sym_idx, w.head.info0, w.head.info1);
        return $sformatf("lanes %h %h %h %h", w.lanes[3], w.lanes[2], w.lanes[1], w.lanes[0]);
    endfunction

    function automatic logic [word_w-1:0] ctrl_word(input int g);
        if (g == head_group)
            return head_m;
        if (g == shift_group0)
            return {shift_m[1], shift_m[0]};
        if (g == shift_group1)
            return {shift_m[3], shift_m[2]};
        return '0;
    endfunction

    // expected writes of one frame in output order
    task automatic push_frame(input bit chk_ctrl);
        logic [group_len*sample_w-1:0] stream;
        cpri_word_u w;
        for (int g = 0; g < num_groups; g++)
        begin
            exp_addr.push_back(g < ctrl_low_groups ? addr_w'(g) : addr_w'(g) + ctrl_high_base);
            exp_data.push_back(ctrl_word(g));
            exp_chk.push_back(chk_ctrl || !(g inside {head_group, shift_group0, shift_group1}));
            for (int k = 1; k < group_len; k++)
            begin
                for (int a = 0; a < num_ant; a++)
                begin
                    for (int j = 0; j < group_len; j++)
                        stream[sample_w*j +: sample_w] = pkt_smp[group_len*g + j][a];
                    w.lanes[a] = stream[lane_w*(k-1) +: lane_w];
                end
                exp_addr.push_back(data_first + addr_w'((group_len - 1)*g + k - 1));
                exp_data.push_back(w);
                exp_chk.push_back(1'b1);
            end
        end
    endtask

    task automatic send_word(input int n, input int w);
        logic [phase_w-1:0]              ph;
        logic [prb_idx_w-1:0]            prb;
        logic [hdr_info_w-1:0]           inf;
        logic [num_ant-1:0][shift_w-1:0] shf;
        ph  = phase_w'(n);
        prb = prb_idx_w'($urandom);
        inf = hdr_info_w'($urandom);
        // first words cover every low PRB value, so all shift nibbles get written
        if (w < 4)
            prb[1:0] = 2'(w);
        for (int a = 0; a < num_ant; a++)
        begin
            pkt_smp[w][a] = sample_w'($urandom);
            shf[a]        = shift_w'($urandom);
            shift_m[a][{ph[phase_w-1], prb[1:0]}] = shf[a];
        end
        i_vld       <= 1'b1;
        i_sop       <= (w == 0);
        i_eop       <= (w == pkt_words - 1);
        i_ant_data  <= pkt_smp[w];
        i_ant_shift <= shf;
        i_prb_idx   <= prb;
        i_info      <= inf;
        i_ch_type   <= ch_type_w'($urandom);
        i_cell_idx  <= 1'($urandom);
        i_slot_idx  <= slot_idx_w'($urandom);
        i_sym_idx   <= sym_idx_w'($urandom);
        #1;
        if (ph == '0)
        begin
            head_m.head.ch_type  = i_ch_type;
            head_m.head.cell_idx = i_cell_idx;
            head_m.head.slot_idx = i_slot_idx;
            head_m.head.sym_idx  = i_sym_idx;
        end
        if (w == 0 && ph == '0)
        begin
            head_m.head.prb0  = prb[prb_w-1:0];
            head_m.head.info0 = inf[hdr_info_w-1 -: info_hi_w];
        end
        if (w == 0 && ph == prb1_phase)
        begin
            head_m.head.prb1  = prb[prb_w-1:0];
            head_m.head.info1 = inf[hdr_info_w-1 -: info_hi_w];
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin
        int  t;
        bit  burst;
        void'($urandom(32'h4729c8a7));
        rst = 1'b1;
        i_vld = 1'b0;
        i_sop = 1'b0;
        i_eop = 1'b0;
        i_ant_data = '0;
        i_ant_shift = '0;
        i_ch_type = '0;
        i_cell_idx = 1'b0;
        i_slot_idx = '0;
        i_sym_idx = '0;
        i_prb_idx = '0;
        i_info = '0;
        head_m = '0;
        shift_m = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < num_pkts; n++)
        begin
            burst = (n % 4) < 2;
            t = 0;
            while (credits == 0)
            begin
                @(posedge clk);
                i_vld <= 1'b0;
                t++;
                if (t > wait_max)
                    die("timeout waiting for a credit");
            end
            credits--;
            for (int w = 0; w < pkt_words; w++)
            begin
                if (!burst)
                begin
                    repeat ($urandom_range(2, 0))
                    begin
                        @(posedge clk);
                        i_vld <= 1'b0;
                    end
                end
                @(posedge clk);
                send_word(n, w);
            end
            // header and shift words hold unwritten fields until phase 4
            push_frame(n >= 4);
        end
        @(posedge clk);
        i_vld <= 1'b0;
        t = 0;
        while (frames_done < num_pkts)
        begin
            @(posedge clk);
            t++;
            if (t > wait_max)
                die("timeout waiting for the output frames");
        end
        repeat (2) @(posedge clk);
        if (credits_seen == num_pkts && exp_addr.size() == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
            die("credit count or expected frame queue wrong at end of run");
    end

    // ------------------------------
    // checks
    // ------------------------------
    always @(posedge clk)
    begin
        int s;
        logic [addr_w-1:0] ea;
        logic [word_w-1:0] ed;
        bit ec;
        cyc <= cyc + 1;
        if (!rst)
        begin
            if (i_vld && i_eop)
                eop_q.push_back(cyc);
            // one credit per frame, the cycle after its last read address
            if (o_credit)
            begin
                credits_seen++;
                credits++;
                assert (cyc == last_s + pkt_words + 1)
                    else die($sformatf("Error: o_credit at cycle %h, expected %h",
                        cyc, last_s + pkt_words + 1));
            end
            if (o_wen)
            begin
                if (wcnt == 0)
                begin
                    assert (eop_q.size() > 0) else die("write with no packet received");
                    s = eop_q.pop_front() + 1;
                    if (last_s + pkt_words > s)
                        s = last_s + pkt_words;
                    assert (cyc == s + 3 + 1)
                        else die($sformatf("Error: o_wen first at cycle %h, expected %h",
                            cyc, s + 4));
                    last_s = s;
                end
                assert (exp_addr.size() > 0) else die("write with no expected frame word");
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                ec = exp_chk.pop_front();
                assert (o_waddr == ea)
                    else die($sformatf("Error: o_waddr got %h exp %h", o_waddr, ea));
                assert (!ec || o_wdata == ed)
                    else die($sformatf("Error: o_wdata at %h got %h exp %h (%s)",
                        ea, o_wdata, ed, show_word(ea, cpri_word_u'(ed))));
                assert (o_wlast == (wcnt == pkt_words - 1))
                    else die($sformatf("Error: o_wlast got %h exp %h at write %h",
                        o_wlast, wcnt == pkt_words - 1, wcnt));
                if (wcnt == pkt_words - 1)
                begin
                    wcnt = 0;
                    frames_done++;
                end
                else
                    wcnt++;
            end
            else
                assert (wcnt == 0) else die("o_wen dropped in the middle of a frame");
        end
    end

    assert property (@(posedge clk) $past(rst) |-> !o_wen && !o_wlast && !o_credit)
        else die("outputs not low after reset");

    assert property (@(posedge clk) o_wlast |-> o_wen)
        else die("o_wlast without o_wen");

endmodule

// File: verilog.f
rtl/frame_pkg.sv
rtl/word_pkg.sv
rtl/pkt_ctrl.sv
rtl/pkt_buffer.sv
rtl/header_capture.sv
rtl/sample_repack.sv
rtl/frame_writer.sv
rtl/cpri_packer.sv
tb/tb_cpri_packer.sv
